// ==== Makefile ====
TOP = hostTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -o V$(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+10 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// ==== flist.f ====
hostPkg.sv
wbBus.sv
z80BusBridge.sv
hostRam.sv
uartIo.sv
keyDebounce.sv
host.sv
hostBus_sva.sv
hostTb.sv

// ==== host.sv ====
`timescale 1ns/1ps

module host (
    input  logic          clk,
    input  logic          reset,
    // Z80 bus, driven by the external master
    input  hostPkg::addrT addr,
    input  hostPkg::dataT dataIn,
    input  logic          nMreq,
    input  logic          nIorq,
    input  logic          nRd,
    input  logic          nWr,
    input  logic          nM1,
    input  logic          nRfsh,
    output hostPkg::dataT dataOut,
    output logic          dataOutEn,
    output logic          nWait,
    // Serial out
    output logic          uartTx,
    // Board keys and the interrupt pins they feed
    input  logic          intKey,
    input  logic          nmiKey,
    output logic          nInt,
    output logic          nNmi
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory space and IO space buses
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    wbBus memBus ();
    wbBus ioBus ();

    z80BusBridge bridge0 (
        .clk       (clk),
        .reset     (reset),
        .addr      (addr),
        .dataIn    (dataIn),
        .nMreq     (nMreq),
        .nIorq     (nIorq),
        .nRd       (nRd),
        .nWr       (nWr),
        .nM1       (nM1),
        .nRfsh     (nRfsh),
        .dataOut   (dataOut),
        .dataOutEn (dataOutEn),
        .nWait     (nWait),
        .memBus    (memBus.master),
        .ioBus     (ioBus.master)
    );

    // 0000-3FFF RAM, aliased up to FFFF
    hostRam ram0 (
        .clk (clk),
        .bus (memBus.slave)
    );

    // IO 00xx UART data, 02xx UART status
    uartIo uart0 (
        .clk    (clk),
        .reset  (reset),
        .bus    (ioBus.slave),
        .uartTx (uartTx)
    );

    keyDebounce keys0 (
        .clk    (clk),
        .reset  (reset),
        .intKey (intKey),
        .nmiKey (nmiKey),
        .nInt   (nInt),
        .nNmi   (nNmi)
    );

endmodule

// ==== hostBus_sva.sv ====
`timescale 1ns/1ps

module hostBusSva (
    input logic                 clk,
    input logic                 reset,
    input logic                 memCyc,
    input logic                 memStb,
    input logic                 memAck,
    input logic                 ioCyc,
    input logic                 ioStb,
    input logic                 ioAck,
    input hostPkg::bridgeStateT bridgeState,
    input logic                 busy,
    input logic                 uartTx,
    input logic                 nWait,
    output logic                anyFail
);
    import hostPkg::*;

    // One sticky flag per property
    logic ackWidthBad = 1'b0;
    logic ackCycleBad = 1'b0;
    logic stbBad = 1'b0;
    logic lineBad = 1'b0;
    logic waitBad = 1'b0;

    assign anyFail = ackWidthBad || ackCycleBad || stbBad || lineBad || waitBad;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wishbone classic handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Ack lasts exactly one cycle
    ackPulse: assert property (@(posedge clk) disable iff (reset)
        (memAck || ioAck) |=> !memAck && !ioAck)
        else begin
            $error("ack held for more than one cycle");
            ackWidthBad = 1'b1;
        end

    // Ack only inside an open cycle
    ackInCycle: assert property (@(posedge clk) disable iff (reset)
        (memAck |-> memCyc && memStb) and (ioAck |-> ioCyc && ioStb))
        else begin
            $error("ack outside a bus cycle");
            ackCycleBad = 1'b1;
        end

    // No new strobe while the CPU is still finishing its access
    quietInWaitEnd: assert property (@(posedge clk) disable iff (reset)
        (bridgeState == waitEnd) |-> !memStb && !ioStb)
        else begin
            $error("stb raised in waitEnd");
            stbBad = 1'b1;
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Line idle and reset values
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    lineIdle: assert property (@(posedge clk) disable iff (reset) !busy |-> uartTx)
        else begin
            $error("uartTx low while not busy");
            lineBad = 1'b1;
        end

    waitAfterReset: assert property (@(posedge clk) $fell(reset) |-> nWait)
        else begin
            $error("nWait low after reset");
            waitBad = 1'b1;
        end

endmodule

bind host hostBusSva sva0 (
    .clk         (clk),
    .reset       (reset),
    .memCyc      (memBus.cyc),
    .memStb      (memBus.stb),
    .memAck      (memBus.ack),
    .ioCyc       (ioBus.cyc),
    .ioStb       (ioBus.stb),
    .ioAck       (ioBus.ack),
    .bridgeState (bridge0.state),
    .busy        (uart0.busy),
    .uartTx      (uartTx),
    .nWait       (nWait),
    .anyFail     ()
);

// ==== hostPkg.sv ====
package hostPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Z80 bus widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Full CPU address, memory and IO space alike
    typedef logic [15:0] addrT;
    // One data byte on the bus
    typedef logic [7:0] dataT;
    // RAM word address, low bits of addrT
    typedef logic [13:0] ramAddrT;
    // IO port number, the upper address byte of an IO cycle
    typedef logic [7:0] ioPortT;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // 16K RAM, repeated four times over 64K
    localparam int ramDepth = 16384;
    // 0000-00FF write a byte to the UART
    localparam ioPortT uartDataPort = 8'h00;
    // 0200-02FF busy flag in bit 0
    localparam ioPortT uartStatusPort = 8'h02;
    // Floating bus value for unmapped ports
    localparam dataT ioIdleData = 8'hFF;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // UART and key timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int clocksPerBit = 16;
    localparam int baudCountWidth = $clog2(clocksPerBit);
    // Start bit, eight data bits, stop bit
    localparam int frameBits = 10;
    localparam int bitCountWidth = $clog2(frameBits);
    // Stable cycles before a key output may change
    localparam int debounceCycles = 64;
    localparam int debounceCountWidth = $clog2(debounceCycles);

    // Bridge sequencing, one Wishbone cycle per Z80 request
    typedef enum logic [1:0] {
        idle,
        busCycle,
        releaseBus,
        waitEnd
    } bridgeStateT;

endpackage

// ==== hostRam.sv ====
`timescale 1ns/1ps

module hostRam (
    input logic  clk,
    wbBus.slave  bus
);
    import hostPkg::*;

    dataT mem [ramDepth];
    ramAddrT ramAddr;
    logic accept;
    logic ackReg;
    dataT rdReg;

    // Upper two address bits are ignored, so the RAM shows up four times
    assign ramAddr = bus.adr[$bits(ramAddrT)-1:0];

    // New request, not the trailing cycle of one already acked
    assign accept = bus.cyc && bus.stb && !ackReg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Single port array
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (accept && bus.we) begin
            mem[ramAddr] <= bus.datWr;
        end
        // Read every cycle, data lines up with ack
        rdReg <= mem[ramAddr];
    end

    // Ack one cycle after stb, exactly one cycle wide
    always_ff @(posedge clk) begin
        ackReg <= accept;
    end

    assign bus.ack = ackReg;
    assign bus.datRd = rdReg;

endmodule

// ==== hostTb.sv ====
`timescale 1ns/1ps

module hostTb;
    import hostPkg::*;

    localparam int timeoutCycles = 60000;
    localparam int ramWrites = 40;
    localparam int holdCycles = 8;

    logic clk = 1'b0;
    logic reset;
    addrT addr;
    dataT dataIn;
    logic nMreq, nIorq, nRd, nWr, nM1, nRfsh;
    dataT dataOut;
    logic dataOutEn, nWait, uartTx;
    logic intKey, nmiKey, nInt, nNmi;

    int seed = 59547;
    int cycleCount = 0;
    // RAM model indexed by the low 14 address bits
    dataT refMem [ramDepth];
    addrT written[$];
    dataT rxBytes[$];
    dataT rxByte;

    host dut0 (.*);

    always #4 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reporting and run limit
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic reportError(input string msg);
        $display("[ERROR] %0d ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkByte(input dataT got, input dataT exp, input string what);
        assert (got == exp) else reportError($sformatf("%s: got %02h, expected %02h",
                                                       what, got, exp));
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == timeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
            $display("Simulation failed");
            $fatal(1, "run aborted on timeout");
        end
    end

    // Sticky failure flag from the bound bus checker
    always @(negedge clk) begin
        assert (!dut0.sva0.anyFail) else reportError("bound bus checker assertion failed");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Z80 bus cycles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic runCycle(input logic isIo, input logic isWrite, input addrT a,
                            input dataT d, output dataT rd);
        @(posedge clk);
        addr <= a;
        dataIn <= d;
        nMreq <= isIo;
        nIorq <= !isIo;
        nWr <= !isWrite;
        nRd <= isWrite;
        // Wait for the wait state and then for its release after the slave ack
        @(negedge clk);
        while (nWait) @(negedge clk);
        while (!nWait) @(negedge clk);
        if (!isWrite) begin
            assert (dataOutEn) else reportError("dataOutEn low at the end of a read");
        end
        rd = dataOut;
        @(posedge clk);
        nMreq <= 1'b1;
        nIorq <= 1'b1;
        nRd <= 1'b1;
        nWr <= 1'b1;
    endtask

    task automatic memWrite(input addrT a, input dataT d);
        dataT unused;
        runCycle(1'b0, 1'b1, a, d, unused);
        refMem[a[13:0]] = d;
    endtask

    task automatic memRead(input addrT a, output dataT d);
        runCycle(1'b0, 1'b0, a, 8'h00, d);
    endtask

    task automatic ioWrite(input addrT a, input dataT d);
        dataT unused;
        runCycle(1'b1, 1'b1, a, d, unused);
    endtask

    task automatic ioRead(input addrT a, output dataT d);
        runCycle(1'b1, 1'b0, a, 8'h00, d);
    endtask

    // Neither a refresh nor an interrupt acknowledge may stall the bus
    task automatic ignoredCycle(input logic isIo, input addrT a, input dataT d);
        @(posedge clk);
        addr <= a;
        dataIn <= d;
        nMreq <= isIo;
        nIorq <= !isIo;
        nWr <= 1'b0;
        nRfsh <= isIo;
        nM1 <= !isIo;
        repeat (holdCycles) begin
            @(negedge clk);
            assert (nWait) else reportError("nWait pulled low by an ignored cycle");
        end
        @(posedge clk);
        nMreq <= 1'b1;
        nIorq <= 1'b1;
        nWr <= 1'b1;
        nRfsh <= 1'b1;
        nM1 <= 1'b1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // UART line decoder sampling mid bit
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always begin
        @(negedge clk);
        if (!reset && uartTx === 1'b0) begin
            repeat (clocksPerBit / 2 - 1) @(negedge clk);
            assert (uartTx == 1'b0) else reportError("UART start bit too short");
            for (int i = 0; i < 8; i++) begin
                repeat (clocksPerBit) @(negedge clk);
                rxByte[i] = uartTx;
            end
            repeat (clocksPerBit) @(negedge clk);
            assert (uartTx == 1'b1) else reportError("UART stop bit missing");
            rxBytes.push_back(rxByte);
        end
    end

    task automatic waitByte(output dataT b);
        while (rxBytes.size() == 0) @(negedge clk);
        b = rxBytes.pop_front();
    endtask

    // Poll the status port until the frame is out
    task automatic waitUartIdle();
        dataT status;
        ioRead({uartStatusPort, 8'h00}, status);
        while (status[0]) ioRead({uartStatusPort, 8'h00}, status);
    endtask

    // nNmi must follow after debounceCycles plus the synchronizer
    task automatic waitNmi(input logic level);
        int count;
        count = 0;
        while (nNmi != level) begin
            @(negedge clk);
            count++;
            assert (count <= debounceCycles + 8) else reportError("nNmi did not follow nmiKey");
        end
        assert (count >= debounceCycles) else reportError("nNmi changed before debounce time");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        addrT a;
        dataT d;
        dataT got;
        reset <= 1'b1;
        addr <= '0;
        dataIn <= '0;
        nMreq <= 1'b1;
        nIorq <= 1'b1;
        nRd <= 1'b1;
        nWr <= 1'b1;
        nM1 <= 1'b1;
        nRfsh <= 1'b1;
        intKey <= 1'b1;
        nmiKey <= 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (nWait && nInt && nNmi && !dataOutEn && uartTx)
            else reportError("outputs not at their reset values");

        // Random RAM writes read back directly and at two aliases
        for (int i = 0; i < ramWrites; i++) begin
            a = 16'($random(seed));
            d = 8'($random(seed));
            memWrite(a, d);
            written.push_back(a);
        end
        foreach (written[i]) begin
            memRead(written[i], got);
            checkByte(got, refMem[written[i][13:0]], "RAM read");
            memRead(written[i] + 16'h4000, got);
            checkByte(got, refMem[written[i][13:0]], "RAM alias +4000");
            memRead(written[i] + 16'hC000, got);
            checkByte(got, refMem[written[i][13:0]], "RAM alias +C000");
        end

        // Refresh write and interrupt acknowledge are ignored
        ignoredCycle(1'b0, written[0], ~refMem[written[0][13:0]]);
        memRead(written[0], got);
        checkByte(got, refMem[written[0][13:0]], "RAM after refresh cycle");
        ignoredCycle(1'b1, {uartDataPort, 8'h00}, 8'h5A);
        assert (uartTx && rxBytes.size() == 0) else reportError("interrupt ack reached UART");

        // Plain UART frames
        repeat (3) begin
            d = 8'($random(seed));
            ioWrite({uartDataPort, 8'($random(seed))}, d);
            waitByte(got);
            checkByte(got, d, "UART frame");
            waitUartIdle();
        end

        // Busy status and a write dropped while busy
        d = 8'($random(seed));
        ioWrite({uartDataPort, 8'h3C}, d);
        ioRead({uartStatusPort, 8'(($random(seed)))}, got);
        checkByte(got, 8'h01, "UART status while busy");
        ioWrite({uartDataPort, 8'h00}, ~d);
        waitByte(got);
        checkByte(got, d, "UART frame after a dropped write");
        repeat (clocksPerBit) @(negedge clk);
        ioRead({uartStatusPort, 8'h00}, got);
        checkByte(got, 8'h00, "UART status after the frame");
        repeat ((frameBits + 2) * clocksPerBit) @(negedge clk);
        assert (rxBytes.size() == 0) else reportError("dropped byte appeared on uartTx");

        // Unmapped port floats high
        ioRead({8'h05, 8'h77}, got);
        checkByte(got, 8'hFF, "unmapped IO read");

        // Short INT glitch is filtered out
        @(posedge clk);
        intKey <= 1'b0;
        repeat (debounceCycles / 2) @(posedge clk);
        intKey <= 1'b1;
        repeat (debounceCycles + 8) begin
            @(negedge clk);
            assert (nInt) else reportError("short intKey pulse reached nInt");
        end

        // Long NMI press and release
        @(posedge clk);
        nmiKey <= 1'b0;
        waitNmi(1'b0);
        @(posedge clk);
        nmiKey <= 1'b1;
        waitNmi(1'b1);

        if (!dut0.sva0.anyFail) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "bound bus checker flagged an error");
        end
    end

endmodule

// ==== keyDebounce.sv ====
`timescale 1ns/1ps

module keyDebounce (
    input  logic clk,
    input  logic reset,
    input  logic intKey,
    input  logic nmiKey,
    output logic nInt,
    output logic nNmi
);
    import hostPkg::*;

    // Index 0 is the INT key, index 1 the NMI key
    logic [1:0] keyIn;
    logic [1:0] sync1;
    logic [1:0] sync2;
    logic [1:0] keyState;
    logic [debounceCountWidth-1:0] stableCnt [2];

    assign keyIn = {nmiKey, intKey};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Synchronizer and stability counter, per key
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            // Keys are active low, so released means high
            sync1 <= 2'b11;
            sync2 <= 2'b11;
            keyState <= 2'b11;
            stableCnt[0] <= '0;
            stableCnt[1] <= '0;
        end else begin
            sync1 <= keyIn;
            sync2 <= sync1;
            for (int i = 0; i < 2; i++) begin
                if (sync2[i] == keyState[i]) begin
                    // Any bounce back restarts the count
                    stableCnt[i] <= '0;
                end else if (stableCnt[i] == debounceCountWidth'(debounceCycles - 1)) begin
                    keyState[i] <= sync2[i];
                    stableCnt[i] <= '0;
                end else begin
                    stableCnt[i] <= stableCnt[i] + 1'b1;
                end
            end
        end
    end

    // Pin polarity matches the keys, no inversion
    assign nInt = keyState[0];
    assign nNmi = keyState[1];

endmodule

// ==== uartIo.sv ====
`timescale 1ns/1ps

module uartIo (
    input  logic clk,
    input  logic reset,
    wbBus.slave  bus,
    output logic uartTx
);
    import hostPkg::*;

    ioPortT port;
    logic accept;
    logic ackReg;
    dataT rdReg;
    logic busy;
    logic [frameBits-1:0] shifter;
    logic [baudCountWidth-1:0] baudCnt;
    logic [bitCountWidth-1:0] bitCnt;
    logic bitDone;
    logic loadFrame;

    // Port is the upper byte of the IO address, as on the Z80
    assign port = bus.adr[15:8];
    assign accept = bus.cyc && bus.stb && !ackReg;

    // Bytes written while a frame is going out are dropped
    assign loadFrame = accept && bus.we && (port == uartDataPort) && !busy;

    assign bitDone = (baudCnt == baudCountWidth'(clocksPerBit - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wishbone slave side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            ackReg <= 1'b0;
        end else begin
            // Every port acks, mapped or not
            ackReg <= accept;
        end
    end

    // Status read shows busy in bit 0, unmapped ports float high
    always_ff @(posedge clk) begin
        if (accept) begin
            if (port == uartStatusPort) begin
                rdReg <= {7'b0, busy};
            end else begin
                rdReg <= ioIdleData;
            end
        end
    end

    assign bus.ack = ackReg;
    assign bus.datRd = rdReg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Transmit shifter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            baudCnt <= '0;
            bitCnt <= '0;
        end else if (loadFrame) begin
            busy <= 1'b1;
            baudCnt <= '0;
            bitCnt <= '0;
        end else if (busy) begin
            if (bitDone) begin
                baudCnt <= '0;
                // Stop bit was the last one out
                if (bitCnt == bitCountWidth'(frameBits - 1)) begin
                    busy <= 1'b0;
                end else begin
                    bitCnt <= bitCnt + 1'b1;
                end
            end else begin
                baudCnt <= baudCnt + 1'b1;
            end
        end
    end

    // Frame is stop, data LSB first, start; shifted right each bit
    always_ff @(posedge clk) begin
        if (loadFrame) begin
            shifter <= {1'b1, bus.datWr, 1'b0};
        end else if (busy && bitDone) begin
            shifter <= {1'b1, shifter[frameBits-1:1]};
        end
    end

    // Registered line, idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            uartTx <= 1'b1;
        end else begin
            uartTx <= busy ? shifter[0] : 1'b1;
        end
    end

endmodule

// ==== wbBus.sv ====
`timescale 1ns/1ps

// Wishbone classic, byte wide, one outstanding cycle
interface wbBus;
    import hostPkg::*;

    logic cyc;
    logic stb;
    logic we;
    addrT adr;
    dataT datWr;
    dataT datRd;
    logic ack;

    // Bridge side
    modport master (
        output cyc, stb, we, adr, datWr,
        input  datRd, ack
    );

    // RAM and IO peripherals
    modport slave (
        input  cyc, stb, we, adr, datWr,
        output datRd, ack
    );

endinterface

// ==== z80BusBridge.sv ====
`timescale 1ns/1ps

module z80BusBridge (
    input  logic          clk,
    input  logic          reset,
    input  hostPkg::addrT addr,
    input  hostPkg::dataT dataIn,
    input  logic          nMreq,
    input  logic          nIorq,
    input  logic          nRd,
    input  logic          nWr,
    input  logic          nM1,
    input  logic          nRfsh,
    output hostPkg::dataT dataOut,
    output logic          dataOutEn,
    output logic          nWait,
    wbBus.master          memBus,
    wbBus.master          ioBus
);
    import hostPkg::*;

    bridgeStateT state;
    logic memReq;
    logic ioReq;
    logic anyStrobe;
    // Wishbone cycle in flight on cyc and stb of the selected bus
    logic active;
    logic selIo;
    logic isWrite;
    addrT adrReg;
    dataT wrReg;
    logic ack;
    dataT rdData;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Refresh cycles carry nMreq without a real access
    assign memReq = !nMreq && (!nRd || !nWr) && nRfsh;
    // nM1 with nIorq marks the interrupt acknowledge rather than an IO access
    assign ioReq = !nIorq && (!nRd || !nWr) && nM1;
    assign anyStrobe = !nMreq || !nIorq || !nRd || !nWr;

    // Response from whichever bus owns the cycle
    assign ack = selIo ? ioBus.ack : memBus.ack;
    assign rdData = selIo ? ioBus.datRd : memBus.datRd;

    // Both buses share the captured address and write data
    assign memBus.cyc = active && !selIo;
    assign memBus.stb = active && !selIo;
    assign memBus.we = isWrite;
    assign memBus.adr = adrReg;
    assign memBus.datWr = wrReg;

    assign ioBus.cyc = active && selIo;
    assign ioBus.stb = active && selIo;
    assign ioBus.we = isWrite;
    assign ioBus.adr = adrReg;
    assign ioBus.datWr = wrReg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cycle sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
            active <= 1'b0;
            selIo <= 1'b0;
            isWrite <= 1'b0;
            nWait <= 1'b1;
            dataOutEn <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    // Memory wins if both strobes show up together
                    if (memReq || ioReq) begin
                        state <= busCycle;
                        active <= 1'b1;
                        selIo <= !memReq;
                        isWrite <= !nWr;
                        nWait <= 1'b0;
                    end
                end
                busCycle: begin
                    // Classic handshake drops cyc and stb right after ack
                    if (ack) begin
                        state <= releaseBus;
                        active <= 1'b0;
                    end
                end
                releaseBus: begin
                    state <= waitEnd;
                    nWait <= 1'b1;
                    dataOutEn <= !isWrite;
                end
                waitEnd: begin
                    // CPU must end the access before another one starts
                    if (!anyStrobe) begin
                        state <= idle;
                        dataOutEn <= 1'b0;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Request address and data capture plus the read data latch
    always_ff @(posedge clk) begin
        if (state == idle) begin
            adrReg <= addr;
            wrReg <= dataIn;
        end
        if (state == busCycle && ack && !isWrite) begin
            dataOut <= rdData;
        end
    end

endmodule
